// File: files.f
+incdir+hdl
hdl/arcade_pkg.sv
hdl/config_port.sv
hdl/pixel_timing.sv
hdl/control_mapper.sv
hdl/color_expand.sv
hdl/scanline_stage.sv
hdl/sigma_delta_dac.sv
hdl/arcade_shell.sv
testbench/tb_arcade_shell.sv

// File: Makefile
# Verilator build and run of the arcade shell testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_arcade_shell
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, then search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@grep -qF '$(PASS_MSG)' $(LOG) || (cat $(LOG); echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: testbench/tb_arcade_shell.sv
//======================================================================
// Testbench for the arcade shell
//  Clock, reset and LFSR driven stimulus
//  Reference models for controls, video expansion and scanlines
//  Checks on config handshake, pixel enable and audio density
//======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_params.svh"

module tb_arcade_shell
	import arcade_pkg::*;
();

	localparam int WAIT_LIMIT = 64;

	logic          clk_sys;
	logic          rst_n;
	logic          cfg_req;
	status_word_t  cfg_data;
	logic          cfg_ack;
	logic          reset_button;
	logic          scan_off;
	kbd_word_t     kbd;
	joy_word_t     joy0;
	joy_word_t     joy1;
	color3_t       core_r;
	color3_t       core_g;
	color2_t       core_b;
	logic          core_hs;
	logic          core_vs;
	logic          core_hblank;
	logic          core_vblank;
	audio_sample_t core_audio;
	logic          ce_pix;
	logic          core_reset;
	core_in_t      in0;
	core_in_t      in1;
	vga_color_t    vga_r;
	vga_color_t    vga_g;
	vga_color_t    vga_b;
	logic          vga_hs;
	logic          vga_vs;
	logic          audio_l;
	logic          audio_r;

	logic [15:0]   lfsr_state;
	logic [31:0]   rnd;
	int            wait_cnt;
	int            ones;
	status_word_t  word;
	// Expected video items in flight, {r6, g6, b6, hs, vs}
	logic [19:0]   exp_q[$];

	arcade_shell i_dut (.*);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	// ==================================================================
	// Failure reporting and basic timing
	// ==================================================================
	task automatic abort_test();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
			abort_test();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		abort_test();
	endtask

	// All driving and sampling happens on the falling edge
	task automatic tick();
		@(negedge clk_sys);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (10) tick();
		rst_n = 1'b1;
	endtask

	// ==================================================================
	// Random source
	// ==================================================================
	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Quarter density, so the ORed directions are not always set
	task automatic draw_sparse(input int n, output logic [31:0] v);
		logic [31:0] a;
		logic [31:0] b;
		draw_bits(n, a);
		draw_bits(n, b);
		v = a & b;
	endtask

	// ==================================================================
	// Reference models
	// ==================================================================
	function automatic status_word_t make_status(input logic rst, input logic rot,
			input scan_mode_t mode);
		status_word_t w;
		w = '0;
		w[`ARC_ST_RESET] = rst;
		w[`ARC_ST_ROTATE] = rot;
		w[`ARC_ST_SCAN_LO +: 2] = mode;
		return w;
	endfunction

	// Returns {in1, in0}
	function automatic logic [15:0] expect_inputs(input kbd_word_t k, input joy_word_t j0,
			input joy_word_t j1, input logic rot);
		logic su;
		logic sd;
		logic sl;
		logic sr;
		logic up;
		logic dn;
		logic lf;
		logic rt;
		logic fire;
		su = k[7] | j0[3] | j1[3];
		sd = k[6] | j0[2] | j1[2];
		sl = k[5] | j0[1] | j1[1];
		sr = k[4] | j0[0] | j1[0];
		// Rotated: up from left, down from right, left from down, right from up
		up = rot ? sl : su;
		dn = rot ? sr : sd;
		lf = rot ? sd : sl;
		rt = rot ? su : sr;
		fire = k[0] | j0[4] | j1[4];
		return {1'b0, k[2], k[1], fire, dn, lf, rt, up,
			1'b1, 1'b1, ~k[3], fire, dn, lf, rt, up};
	endfunction

	// 3-3-2 to 6-6-6, black during blanking
	function automatic logic [17:0] expect_color(input color3_t r, input color3_t g,
			input color2_t b, input logic blank);
		if (blank)
			return '0;
		return {r, r, g, g, b, b, b};
	endfunction

	function automatic vga_color_t expect_scan(input vga_color_t v, input scan_mode_t mode,
			input logic dim);
		if (!dim)
			return v;
		if (mode == 2'd2)
			return v - (v >> 2);
		if (mode == 2'd3)
			return v >> 1;
		return v;
	endfunction

	// ==================================================================
	// Stimulus tasks
	// ==================================================================
	// Four-phase write, ack must follow req by exactly one edge
	task automatic host_write(input status_word_t w);
		check_value("cfg_ack", 32'(cfg_ack), 32'd0);
		cfg_data = w;
		cfg_req = 1'b1;
		wait_cnt = 0;
		while (cfg_ack !== 1'b1) begin
			tick();
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				report_timeout("cfg_ack to rise");
		end
		check_value("cfg_ack latency", wait_cnt, 32'd1);
		check_value("status", i_dut.status, w);
		// Data may move once ack is seen
		cfg_req = 1'b0;
		cfg_data = ~w;
		wait_cnt = 0;
		while (cfg_ack !== 1'b0) begin
			tick();
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				report_timeout("cfg_ack to fall");
		end
		check_value("status", i_dut.status, w);
	endtask

	task automatic run_controls(input int count, input logic rot);
		logic [15:0] exp;
		repeat (count) begin
			draw_sparse(10, rnd);
			kbd = rnd[9:0];
			draw_sparse(8, rnd);
			joy0 = rnd[7:0];
			draw_sparse(8, rnd);
			joy1 = rnd[7:0];
			exp = expect_inputs(kbd, joy0, joy1, rot);
			tick();
			check_value("in0", 32'(in0), 32'(exp[7:0]));
			check_value("in1", 32'(in1), 32'(exp[15:8]));
		end
	endtask

	// Two items always in flight, checked as they leave the pipeline
	task automatic run_video(input int count);
		logic [19:0] exp;
		exp_q.delete();
		repeat (count) begin
			if (exp_q.size() == 2) begin
				exp = exp_q.pop_front();
				check_value("vga_r", 32'(vga_r), 32'(exp[19:14]));
				check_value("vga_g", 32'(vga_g), 32'(exp[13:8]));
				check_value("vga_b", 32'(vga_b), 32'(exp[7:2]));
				check_value("vga_hs", 32'(vga_hs), 32'(exp[1]));
				check_value("vga_vs", 32'(vga_vs), 32'(exp[0]));
			end
			draw_bits(8, rnd);
			core_r = rnd[2:0];
			core_g = rnd[5:3];
			core_b = rnd[7:6];
			draw_bits(8, rnd);
			core_hblank = (rnd[2:0] == 3'd0);
			core_vblank = (rnd[5:3] == 3'd0);
			core_hs = rnd[6];
			core_vs = rnd[7];
			exp_q.push_back({expect_color(core_r, core_g, core_b, core_hblank | core_vblank),
				core_hs, core_vs});
			tick();
		end
	endtask

	// Frame start, then n_hs lines, then a few held colours
	task automatic run_scanlines(input scan_mode_t mode, input int n_hs, input logic off);
		logic [17:0] exp;
		logic        dim;
		scan_off = off;
		core_hblank = 1'b0;
		core_vblank = 1'b0;
		core_hs = 1'b0;
		core_vs = 1'b1;
		tick();
		core_vs = 1'b0;
		tick();
		repeat (n_hs) begin
			core_hs = 1'b1;
			tick();
			core_hs = 1'b0;
			tick();
		end
		dim = n_hs[0] & ~off;
		repeat (4) begin
			draw_bits(8, rnd);
			core_r = rnd[2:0];
			core_g = rnd[5:3];
			core_b = rnd[7:6];
			exp = expect_color(core_r, core_g, core_b, 1'b0);
			tick();
			tick();
			check_value("vga_r", 32'(vga_r), 32'(expect_scan(exp[17:12], mode, dim)));
			check_value("vga_g", 32'(vga_g), 32'(expect_scan(exp[11:6], mode, dim)));
			check_value("vga_b", 32'(vga_b), 32'(expect_scan(exp[5:0], mode, dim)));
		end
	endtask

	// Ones counted over the first 256 cycles after reset
	task automatic run_dac();
		draw_bits(8, rnd);
		core_audio = rnd[7:0];
		apply_reset();
		ones = 0;
		repeat (256) begin
			tick();
			if (audio_l)
				ones++;
			check_value("audio_r", 32'(audio_r), 32'(audio_l));
		end
		check_value("audio_l ones", ones, 32'(core_audio));
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin
		rst_n = 1'b0;
		cfg_req = 1'b0;
		cfg_data = '0;
		reset_button = 1'b0;
		scan_off = 1'b0;
		kbd = '0;
		joy0 = '0;
		joy1 = '0;
		core_r = '0;
		core_g = '0;
		core_b = '0;
		core_hs = 1'b0;
		core_vs = 1'b0;
		core_hblank = 1'b0;
		core_vblank = 1'b0;
		// Full-scale sample, carries on the first add unless the accumulator is cleared
		core_audio = 8'hff;
		lfsr_state = 16'd60791;
		apply_reset();
		// Values still held from reset
		check_value("cfg_ack", 32'(cfg_ack), 32'd0);
		check_value("status", i_dut.status, 32'd0);
		check_value("audio_l", 32'(audio_l), 32'd0);
		tick();
		// First cycle out of reset
		check_value("core_reset", 32'(core_reset), 32'd0);
		check_value("vga_r", 32'(vga_r), 32'd0);
		check_value("vga_g", 32'(vga_g), 32'd0);
		check_value("vga_b", 32'(vga_b), 32'd0);
		check_value("vga_hs", 32'(vga_hs), 32'd0);
		check_value("vga_vs", 32'(vga_vs), 32'd0);
		check_value("audio_l", 32'(audio_l), 32'd0);

		// Config handshake and core reset sources
		host_write(make_status(1'b1, 1'b0, 2'd0));
		tick();
		check_value("core_reset", 32'(core_reset), 32'd1);
		host_write(make_status(1'b0, 1'b1, 2'd3));
		tick();
		check_value("core_reset", 32'(core_reset), 32'd0);
		word = '0;
		word[`ARC_ST_RESET_OSD] = 1'b1;
		host_write(word);
		tick();
		check_value("core_reset", 32'(core_reset), 32'd1);
		host_write(make_status(1'b0, 1'b0, 2'd0));
		reset_button = 1'b1;
		tick();
		check_value("core_reset", 32'(core_reset), 32'd1);
		reset_button = 1'b0;
		tick();
		check_value("core_reset", 32'(core_reset), 32'd0);

		// Pixel enable period and width
		wait_cnt = 0;
		while (ce_pix !== 1'b1) begin
			tick();
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				report_timeout("ce_pix pulse");
		end
		repeat (8) begin
			repeat (`ARC_CE_DIV - 1) begin
				tick();
				check_value("ce_pix", 32'(ce_pix), 32'd0);
			end
			tick();
			check_value("ce_pix", 32'(ce_pix), 32'd1);
		end

		// Controls, plain then rotated
		run_controls(40, 1'b0);
		host_write(make_status(1'b0, 1'b1, 2'd0));
		run_controls(40, 1'b1);

		// Colour, blanking and sync delay in mode 0
		host_write(make_status(1'b0, 1'b0, 2'd0));
		run_video(200);

		// CRT scanline modes, then scan_off
		for (int m = 2; m < 4; m++) begin
			host_write(make_status(1'b0, 1'b0, scan_mode_t'(m)));
			for (int n = 0; n < 4; n++)
				run_scanlines(scan_mode_t'(m), n, 1'b0);
			run_scanlines(scan_mode_t'(m), 3, 1'b1);
			run_scanlines(scan_mode_t'(m), 5, 1'b1);
		end
		scan_off = 1'b0;

		// Audio density, two samples
		run_dac();
		run_dac();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/arcade_shell.sv
//====================================================================
// Arcade platform shell, top level
//  Config port, pixel timing, control mapping
//  Two-stage video path and sigma-delta audio
//====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_params.svh"

module arcade_shell
	import arcade_pkg::*;
(
	input  wire           clk_sys,
	input  wire           rst_n,
	// Host configuration
	input  wire           cfg_req,
	input  status_word_t  cfg_data,
	output logic          cfg_ack,
	input  wire           reset_button,
	input  wire           scan_off,
	// Player controls
	input  kbd_word_t     kbd,
	input  joy_word_t     joy0,
	input  joy_word_t     joy1,
	// Core video and audio
	input  color3_t       core_r,
	input  color3_t       core_g,
	input  color2_t       core_b,
	input  wire           core_hs,
	input  wire           core_vs,
	input  wire           core_hblank,
	input  wire           core_vblank,
	input  audio_sample_t core_audio,
	// Towards the core
	output logic          ce_pix,
	output logic          core_reset,
	output core_in_t      in0,
	output core_in_t      in1,
	// Board outputs
	output vga_color_t    vga_r,
	output vga_color_t    vga_g,
	output vga_color_t    vga_b,
	output logic          vga_hs,
	output logic          vga_vs,
	output logic          audio_l,
	output logic          audio_r
);

	status_word_t status;
	scan_mode_t   scan_mode;
	logic         rotate;
	logic         line_odd;
	vga_color_t   r6;
	vga_color_t   g6;
	vga_color_t   b6;
	logic         hs_d;
	logic         vs_d;

	// Menu options out of the status word
	assign rotate    = status[`ARC_ST_ROTATE];
	assign scan_mode = status[`ARC_ST_SCAN_LO+1:`ARC_ST_SCAN_LO];

	config_port i_config_port (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.cfg_req      (cfg_req),
		.cfg_data     (cfg_data),
		.cfg_ack      (cfg_ack),
		.reset_button (reset_button),
		.status       (status),
		.core_reset   (core_reset)
	);

	pixel_timing i_pixel_timing (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.hs       (core_hs),
		.vs       (core_vs),
		.ce_pix   (ce_pix),
		.line_odd (line_odd)
	);

	control_mapper i_control_mapper (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rotate  (rotate),
		.kbd     (kbd),
		.joy0    (joy0),
		.joy1    (joy1),
		.in0     (in0),
		.in1     (in1)
	);

	// ================================================================
	// Video path, two registers from core to VGA pins
	// ================================================================
	color_expand i_color_expand (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.r       (core_r),
		.g       (core_g),
		.b       (core_b),
		.hblank  (core_hblank),
		.vblank  (core_vblank),
		.hs      (core_hs),
		.vs      (core_vs),
		.r6      (r6),
		.g6      (g6),
		.b6      (b6),
		.hs_d    (hs_d),
		.vs_d    (vs_d)
	);

	scanline_stage i_scanline_stage (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.r6        (r6),
		.g6        (g6),
		.b6        (b6),
		.hs_d      (hs_d),
		.vs_d      (vs_d),
		.line_odd  (line_odd),
		.scan_mode (scan_mode),
		.scan_off  (scan_off),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	// Mono sound, one modulator feeds both pins
	sigma_delta_dac i_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (core_audio),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l;

endmodule

`default_nettype wire

// File: hdl/sigma_delta_dac.sv
//====================================================================
// Audio DAC
//  First-order sigma-delta modulator, 8-bit unsigned input
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac
	import arcade_pkg::*;
(
	input  wire           clk_sys,
	input  wire           rst_n,
	input  audio_sample_t sample,
	output logic          dac_out
);

	// Bit 8 is the carry of the last addition
	logic [8:0] acc;

	// Error feedback is the low byte, the carry leaves as the pulse
	// Density of ones equals sample/256
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[7:0]} + {1'b0, sample};
	end

	assign dac_out = acc[8];

endmodule

`default_nettype wire

// File: hdl/scanline_stage.sv
//====================================================================
// Video stage 2
//  CRT scanline dimming of odd lines
//  Registered VGA colour and sync outputs
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module scanline_stage
	import arcade_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  vga_color_t r6,
	input  vga_color_t g6,
	input  vga_color_t b6,
	input  wire        hs_d,
	input  wire        vs_d,
	input  wire        line_odd,
	input  scan_mode_t scan_mode,
	input  wire        scan_off,
	output vga_color_t vga_r,
	output vga_color_t vga_g,
	output vga_color_t vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic dim_on;

	// Dimming for one channel
	// mode 2 keeps three quarters, mode 3 keeps half
	function automatic vga_color_t dim(input vga_color_t v, input scan_mode_t mode);
		vga_color_t res;
		case (mode)
			2'd2:    res = v - (v >> 2);
			2'd3:    res = v >> 1;
			// none and hq2x leave the pixel alone
			default: res = v;
		endcase
		return res;
	endfunction

	// Only odd lines are darkened, and only when not switched off
	assign dim_on = line_odd & ~scan_off;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= dim_on ? dim(r6, scan_mode) : r6;
			vga_g  <= dim_on ? dim(g6, scan_mode) : g6;
			vga_b  <= dim_on ? dim(b6, scan_mode) : b6;
			vga_hs <= hs_d;
			vga_vs <= vs_d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/color_expand.sv
//====================================================================
// Video stage 1
//  3-3-2 colour widened to 6-6-6 by bit replication
//  Blanking applied, syncs delayed to stay aligned
//====================================================================
`timescale 1ns/1ps
`default_nettype none

module color_expand
	import arcade_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  color3_t    r,
	input  color3_t    g,
	input  color2_t    b,
	input  wire        hblank,
	input  wire        vblank,
	input  wire        hs,
	input  wire        vs,
	output vga_color_t r6,
	output vga_color_t g6,
	output vga_color_t b6,
	output logic       hs_d,
	output logic       vs_d
);

	logic blank;

	assign blank = hblank | vblank;

	// Replication keeps full white at 6'h3f and black at 0
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			r6   <= '0;
			g6   <= '0;
			b6   <= '0;
			hs_d <= 1'b0;
			vs_d <= 1'b0;
		end else begin
			r6   <= blank ? '0 : {r, r};
			g6   <= blank ? '0 : {g, g};
			b6   <= blank ? '0 : {b, b, b};
			// Syncs take the same single register
			hs_d <= hs;
			vs_d <= vs;
		end
	end

endmodule

`default_nettype wire

// File: hdl/control_mapper.sv
//====================================================================
// Control mapper
//  Keyboard and two joysticks merged into the core input words
//  Optional 90 degree rotation of the directions
//====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_params.svh"

module control_mapper
	import arcade_pkg::*;
(
	input  wire       clk_sys,
	input  wire       rst_n,
	input  wire       rotate,
	input  kbd_word_t kbd,
	input  joy_word_t joy0,
	input  joy_word_t joy1,
	output core_in_t  in0,
	output core_in_t  in1
);

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	// Raw directions, any source may press
	assign src_right = kbd[4] | joy0[0] | joy1[0];
	assign src_left  = kbd[5] | joy0[1] | joy1[1];
	assign src_down  = kbd[6] | joy0[2] | joy1[2];
	assign src_up    = kbd[7] | joy0[3] | joy1[3];

	// Rotated cabinet, quarter turn of the stick
	assign m_up    = rotate ? src_left  : src_up;
	assign m_down  = rotate ? src_right : src_down;
	assign m_left  = rotate ? src_down  : src_left;
	assign m_right = rotate ? src_up    : src_right;

	assign m_fire = kbd[0] | joy0[4] | joy1[4];

	// ============================================================
	// Core input words
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			in0 <= '0;
			in1 <= '0;
		end else begin
			// Coin is active low at the core, top two bits tied high
			in0 <= {2'b11, ~kbd[3], m_fire, m_down, m_left, m_right, m_up};
			// start2, start1 above the shared stick bits
			in1 <= {1'b0, kbd[2], kbd[1], m_fire, m_down, m_left, m_right, m_up};
		end
	end

endmodule

`default_nettype wire

// File: hdl/pixel_timing.sv
//====================================================================
// Pixel timing
//  One-cycle pixel clock enable every ARC_CE_DIV clk_sys cycles
//  Odd/even line tracking from the core syncs
//====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_params.svh"

module pixel_timing (
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  hs,
	input  wire  vs,
	output logic ce_pix,
	output logic line_odd
);

	localparam int CNT_W = $clog2(`ARC_CE_DIV);

	logic [CNT_W-1:0] div_cnt;
	logic             hs_q;

	// Modulo divider, pulse on the last count so the period is exact
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ce_pix  <= 1'b0;
		end else begin
			if (div_cnt == CNT_W'(`ARC_CE_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			ce_pix <= (div_cnt == CNT_W'(`ARC_CE_DIV - 1));
		end
	end

	// Line parity
	// hs rising edge flips the parity, vs holds it at even
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_q     <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_q <= hs;
			if (vs)
				line_odd <= 1'b0;
			else if (hs && !hs_q)
				line_odd <= ~line_odd;
		end
	end

endmodule

`default_nettype wire

// File: hdl/config_port.sv
//====================================================================
// Configuration receiver
//  Four-phase req/ack handshake holding the host status word
//  Registered core reset from status bits and the reset button
//====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "arcade_params.svh"

module config_port
	import arcade_pkg::*;
(
	input  wire          clk_sys,
	input  wire          rst_n,
	input  wire          cfg_req,
	input  status_word_t cfg_data,
	output logic         cfg_ack,
	input  wire          reset_button,
	output status_word_t status,
	output logic         core_reset
);

	cfg_state_t state;

	// Handshake FSM
	// Word is captured only on the idle to acked step, so the host
	// may change cfg_data freely once it sees ack
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state  <= cfg_idle;
			status <= '0;
		end else begin
			case (state)
				cfg_idle: begin
					if (cfg_req) begin
						status <= cfg_data;
						state  <= cfg_acked;
					end
				end
				cfg_acked: begin
					// Wait for the host to drop req before a new transfer
					if (!cfg_req)
						state <= cfg_idle;
				end
				default: state <= cfg_idle;
			endcase
		end
	end

	// Ack is simply the acked state, already a flop output
	assign cfg_ack = (state == cfg_acked);

	// Reset sources: menu reset, OSD reset entry and the board button
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			core_reset <= 1'b0;
		else
			core_reset <= status[`ARC_ST_RESET] | status[`ARC_ST_RESET_OSD] | reset_button;
	end

endmodule

`default_nettype wire

// File: hdl/arcade_pkg.sv
//====================================================================
// Shared types of the arcade shell
//  Colour, audio, status and control word vectors
//  Configuration port FSM states
//====================================================================
`default_nettype none

package arcade_pkg;

	// Core colour as delivered, 3-3-2
	typedef logic [2:0] color3_t;
	typedef logic [1:0] color2_t;

	// One VGA channel after expansion
	typedef logic [5:0] vga_color_t;

	// Unsigned audio sample from the core
	typedef logic [7:0] audio_sample_t;

	// Host status word
	typedef logic [31:0] status_word_t;

	// Joystick, bit 0 right, 1 left, 2 down, 3 up, 4 fire
	typedef logic [7:0] joy_word_t;

	// Decoded keys, 0 fire, 1 start1, 2 start2, 3 coin, 4..7 right/left/down/up
	typedef logic [9:0] kbd_word_t;

	// Input port word seen by the core
	typedef logic [7:0] core_in_t;

	// Scanline mode, 0 none, 1 hq2x, 2 CRT 25 %, 3 CRT 50 %
	typedef logic [1:0] scan_mode_t;

	// Four-phase handshake states
	typedef enum logic {
		cfg_idle,
		cfg_acked
	} cfg_state_t;

endpackage

`default_nettype wire

// File: hdl/arcade_params.svh
//====================================================================
// Shell-wide constants
//  Pixel enable divide ratio from clk_sys
//  Bit positions inside the host status word
//====================================================================
`ifndef ARCADE_PARAMS_SVH
`define ARCADE_PARAMS_SVH

// clk_sys cycles per pixel enable, 24 MHz down to 6 MHz
`define ARC_CE_DIV 4

// Status word bit map, as set by the host menu
`define ARC_ST_RESET 0
`define ARC_ST_ROTATE 2
// Scanline selector occupies this bit and the one above it
`define ARC_ST_SCAN_LO 3
`define ARC_ST_RESET_OSD 6

`endif
